/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // physical register tags, register zero is hard zero
    localparam int PREG_W = 6;
    localparam int NUM_PREGS = 1 << PREG_W;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0] rob_tag_t;

    // 0: alu/branch pipe, 1: alu/memory pipe
    typedef logic pipe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        pipe_t    pipe;
        preg_t    src1;
        preg_t    src2;
        logic     src1_ready;
        logic     src2_ready;
        preg_t    dest;
        logic     rf_we;
        rob_tag_t rob_tag;
    } dispatch_entry_t;

    // same layout as dispatch, ready bits change on wakeup
    typedef struct packed {
        logic     valid;
        word_t    pc;
        pipe_t    pipe;
        preg_t    src1;
        preg_t    src2;
        logic     src1_ready;
        logic     src2_ready;
        preg_t    dest;
        logic     rf_we;
        rob_tag_t rob_tag;
    } queue_entry_t;

    typedef struct packed {
        logic  we;
        preg_t dest;
        word_t result;
    } wb_bus_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        preg_t    dest;
        logic     rf_we;
        word_t    src1_value;
        word_t    src2_value;
        rob_tag_t rob_tag;
    } exec_bus_t;

endpackage

`default_nettype wire

/* hw/issue_regfile.sv */
`default_nettype none

module issue_regfile import issue_pkg::*; (
    input  logic          clk,
    input  preg_t [3:0]   raddr,
    output word_t [3:0]   rdata,
    input  wb_bus_t [1:0] wb
);

    word_t mem [NUM_PREGS];

    // port one is written last so it wins on a clash
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (wb[k].we && wb[k].dest != '0) begin
                mem[wb[k].dest] <= wb[k].result;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            if (raddr[r] == '0) begin
                rdata[r] = '0;
            end else begin
                rdata[r] = mem[raddr[r]];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/operand_bypass.sv */
`default_nettype none

module operand_bypass import issue_pkg::*; (
    input  preg_t [1:0]   src,
    input  word_t [1:0]   rf_data,
    input  wb_bus_t [1:0] wb,
    output word_t [1:0]   value
);

    logic [1:0][1:0] hit;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                hit[s][k] = wb[k].we && wb[k].dest == src[s] && src[s] != '0;
            end
        end
    end

    // same-cycle writeback is newer than the array
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            value[s] = rf_data[s];
            for (int k = 0; k < 2; k++) begin
                if (hit[s][k]) begin
                    value[s] = wb[k].result;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/issue_queue.sv */
`default_nettype none

module issue_queue import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic                                     in_valid,
    input  dispatch_entry_t [1:0]                    dispatch,
    output logic                                     in_ready,
    input  wb_bus_t [1:0]                            wb,
    input  logic [1:0]                               pick_valid,
    input  logic [1:0][$clog2(QUEUE_DEPTH)-1:0]      pick_index,
    output queue_entry_t [QUEUE_DEPTH-1:0]           entries
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [CNT_W-1:0]               count;
    logic                           accept;
    logic [1:0]                     n_in;
    logic [1:0]                     n_out;
    logic [QUEUE_DEPTH-1:0]         keep;
    queue_entry_t [QUEUE_DEPTH-1:0] next_entries;

    // set source ready bits on a matching writeback
    function automatic queue_entry_t wake(queue_entry_t e, wb_bus_t [1:0] w);
        queue_entry_t r;
        r = e;
        for (int k = 0; k < 2; k++) begin
            if (w[k].we && w[k].dest == e.src1) begin
                r.src1_ready = 1'b1;
            end
            if (w[k].we && w[k].dest == e.src2) begin
                r.src2_ready = 1'b1;
            end
        end
        return r;
    endfunction

    // room for two more, whatever the dispatch slots hold
    assign in_ready = count <= CNT_W'(QUEUE_DEPTH - 2);
    assign accept = in_valid && in_ready;

    assign n_in = accept ? {1'b0, dispatch[0].valid} + {1'b0, dispatch[1].valid} : 2'd0;
    assign n_out = {1'b0, pick_valid[0]} + {1'b0, pick_valid[1]};

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            keep[i] = entries[i].valid;
            for (int p = 0; p < 2; p++) begin
                if (pick_valid[p] && pick_index[p] == IDX_W'(i)) begin
                    keep[i] = 1'b0;
                end
            end
        end
    end

    // survivors slide down in age order, new slots go behind them
    always_comb begin
        int unsigned pos;
        pos = 0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            next_entries[i] = '0;
        end
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (keep[i]) begin
                next_entries[pos] = wake(entries[i], wb);
                pos = pos + 1;
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (accept && dispatch[k].valid && pos < QUEUE_DEPTH) begin
                next_entries[pos] = wake(queue_entry_t'(dispatch[k]), wb);
                pos = pos + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            count <= '0;
        end else begin
            entries <= next_entries;
            count <= count + CNT_W'(n_in) - CNT_W'(n_out);
        end
    end

endmodule

`default_nettype wire

/* hw/issue_select.sv */
`default_nettype none

module issue_select import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  queue_entry_t [QUEUE_DEPTH-1:0]           entries,
    input  logic [1:0]                               pipe_ready,
    output logic [1:0]                               pick_valid,
    output logic [1:0][$clog2(QUEUE_DEPTH)-1:0]      pick_index
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    logic [1:0][QUEUE_DEPTH-1:0] ready;

    // an entry can go when it is valid, both sources are in and its pipe is free
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                ready[p][i] = entries[i].valid
                    && entries[i].pipe == pipe_t'(p)
                    && entries[i].src1_ready
                    && entries[i].src2_ready
                    && pipe_ready[p];
            end
        end
    end

    // lowest index is the oldest, so scan downward and let it win
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            pick_valid[p] = 1'b0;
            pick_index[p] = '0;
            for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
                if (ready[p][i]) begin
                    pick_valid[p] = 1'b1;
                    pick_index[p] = IDX_W'(i);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/issue_stage.sv */
`default_nettype none

module issue_stage import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  in_valid,
    input  dispatch_entry_t [1:0] dispatch,
    output logic                  in_ready,
    input  wb_bus_t [1:0]         wb,
    input  logic [1:0]            pipe_ready,
    output exec_bus_t [1:0]       exec
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    queue_entry_t [QUEUE_DEPTH-1:0] entries;
    logic [1:0]                     pick_valid;
    logic [1:0][IDX_W-1:0]          pick_index;
    queue_entry_t [1:0]             picked;
    queue_entry_t [1:0]             issued;
    preg_t [3:0]                    raddr;
    word_t [3:0]                    rdata;
    word_t [1:0]                    opnd [2];

    issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .dispatch   (dispatch),
        .in_ready   (in_ready),
        .wb         (wb),
        .pick_valid (pick_valid),
        .pick_index (pick_index),
        .entries    (entries)
    );

    issue_select #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_select (
        .entries    (entries),
        .pipe_ready (pipe_ready),
        .pick_valid (pick_valid),
        .pick_index (pick_index)
    );

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            picked[p] = entries[pick_index[p]];
            picked[p].valid = pick_valid[p];
        end
    end

    // issue register, only ever loads what select picked
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issued[0].valid <= 1'b0;
            issued[1].valid <= 1'b0;
        end else begin
            issued <= picked;
        end
    end

    assign raddr[0] = issued[0].src1;
    assign raddr[1] = issued[0].src2;
    assign raddr[2] = issued[1].src1;
    assign raddr[3] = issued[1].src2;

    issue_regfile u_regfile (
        .clk   (clk),
        .raddr (raddr),
        .rdata (rdata),
        .wb    (wb)
    );

    for (genvar p = 0; p < 2; p++) begin : g_pipe
        operand_bypass u_bypass (
            .src     ({issued[p].src2, issued[p].src1}),
            .rf_data ({rdata[2*p+1], rdata[2*p]}),
            .wb      (wb),
            .value   (opnd[p])
        );
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            exec[p].valid      = issued[p].valid;
            exec[p].pc         = issued[p].pc;
            exec[p].dest       = issued[p].dest;
            exec[p].rf_we      = issued[p].rf_we;
            exec[p].src1_value = opnd[p][0];
            exec[p].src2_value = opnd[p][1];
            exec[p].rob_tag    = issued[p].rob_tag;
        end
    end

endmodule

`default_nettype wire

/* tests/issue_stage_checker.sv */
`default_nettype none

module issue_stage_checker import issue_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            flush,
    input logic            in_ready,
    input logic [1:0]      pipe_ready,
    input exec_bus_t [1:0] exec
);

    // a flush clears the issue register at its edge
    flush_clears_exec: assert property (@(posedge clk) disable iff (rst)
        $past(flush) |-> !exec[0].valid && !exec[1].valid)
        else $error("exec valid in the cycle after a flush");

    reset_opens_queue: assert property (@(posedge clk)
        $past(rst) && !rst |-> in_ready)
        else $error("in_ready low in the cycle after reset");

    // select is gated by pipe_ready one cycle before the bundle shows
    for (genvar p = 0; p < 2; p++) begin : g_pipe
        issue_follows_ready: assert property (@(posedge clk) disable iff (rst)
            exec[p].valid |-> $past(pipe_ready[p]))
            else $error("exec[%0d] valid without pipe_ready one cycle earlier", p);
    end

endmodule

bind issue_stage issue_stage_checker checker0 (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .in_ready   (in_ready),
    .pipe_ready (pipe_ready),
    .exec       (exec)
);

`default_nettype wire

/* tests/issue_stage_tb.sv */
`default_nettype none

module issue_stage_tb import issue_pkg::*; ();

    localparam int QUEUE_DEPTH = 8;
    // the directed tests need roughly 150 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct {
        dispatch_entry_t d;
        int              due;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  in_valid;
    dispatch_entry_t [1:0] dispatch;
    logic                  in_ready;
    wb_bus_t [1:0]         wb;
    logic [1:0]            pipe_ready;
    exec_bus_t [1:0]       exec;

    word_t       ref_regs [NUM_PREGS];
    expect_t     exp_q [2][$];
    int          cycle;
    int          error_count;
    logic [31:0] lcg_state;

    issue_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .dispatch   (dispatch),
        .in_ready   (in_ready),
        .wb         (wb),
        .pipe_ready (pipe_ready),
        .exec       (exec)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
            input logic [31:0] want);
        assert (got === want)
            else fail_now($sformatf("mismatch %s: got %h, expected %h", name, got, want));
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // register zero always reads zero
    function automatic word_t operand_value(input preg_t src);
        return (src == '0) ? '0 : ref_regs[src];
    endfunction

    function automatic dispatch_entry_t make_entry(input word_t pc, input pipe_t pipe,
            input preg_t src1, input logic rdy1, input preg_t src2, input logic rdy2,
            input preg_t dest, input rob_tag_t rob_tag);
        dispatch_entry_t e;
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.pipe = pipe;
        e.src1 = src1;
        e.src2 = src2;
        e.src1_ready = rdy1;
        e.src2_ready = rdy2;
        e.dest = dest;
        e.rf_we = 1'b1;
        e.rob_tag = rob_tag;
        return e;
    endfunction

    task automatic expect_exec(input int p, input dispatch_entry_t d, input int due);
        expect_t x;
        x.d = d;
        x.due = due;
        exp_q[p].push_back(x);
    endtask

    // called on a rising edge, the reference sees the value in the same cycle
    task automatic drive_wb(input int port, input preg_t dest, input word_t value);
        wb[port].we <= 1'b1;
        wb[port].dest <= dest;
        wb[port].result <= value;
        if (dest != '0) begin
            ref_regs[dest] = value;
        end
    endtask

    // returns the number of the edge that accepted the pair
    task automatic send(input dispatch_entry_t e0, input dispatch_entry_t e1, output int acc);
        @(posedge clk);
        in_valid <= 1'b1;
        dispatch[0] <= e0;
        dispatch[1] <= e1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        acc = cycle + 1;
        @(posedge clk);
        in_valid <= 1'b0;
        dispatch <= '0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q[0].size() + exp_q[1].size() > 0) begin
            @(negedge clk);
            waited++;
            assert (waited <= limit)
                else fail_now("expected exec bundles did not arrive in time");
        end
    endtask

    task automatic check_pipe(input int p);
        expect_t x;
        string name;
        name = $sformatf("exec[%0d]", p);
        if (exec[p].valid) begin
            assert (exp_q[p].size() > 0)
                else fail_now($sformatf("%s issued an instruction nobody expected", name));
            x = exp_q[p].pop_front();
            check_word({name, ".pc"}, exec[p].pc, x.d.pc);
            check_word({name, ".dest"}, 32'(exec[p].dest), 32'(x.d.dest));
            check_word({name, ".rf_we"}, 32'(exec[p].rf_we), 32'(x.d.rf_we));
            check_word({name, ".rob_tag"}, 32'(exec[p].rob_tag), 32'(x.d.rob_tag));
            check_word({name, ".src1_value"}, exec[p].src1_value, operand_value(x.d.src1));
            check_word({name, ".src2_value"}, exec[p].src2_value, operand_value(x.d.src2));
            if (x.due >= 0) begin
                check_word({name, " issue cycle"}, cycle, x.due);
            end
        end else begin
            assert (exp_q[p].size() == 0 || exp_q[p][0].due != cycle)
                else fail_now($sformatf("%s did not issue at cycle %0d", name, cycle));
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout, tests still running after %0d cycles", cycle));
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < 2; p++) begin
                check_pipe(p);
            end
        end
    end

    task automatic reset_state_check();
        @(negedge clk);
        assert (!exec[0].valid && !exec[1].valid) else fail_now("exec valid right after reset");
        assert (in_ready) else fail_now("in_ready low right after reset");
    endtask

    task automatic load_regs();
        for (int r = 1; r < NUM_PREGS - 1; r += 2) begin
            @(posedge clk);
            drive_wb(0, preg_t'(r), next_rand());
            drive_wb(1, preg_t'(r + 1), next_rand());
        end
        // both ports on one register, port one wins
        @(posedge clk);
        drive_wb(0, preg_t'(NUM_PREGS - 1), next_rand());
        drive_wb(1, preg_t'(NUM_PREGS - 1), next_rand());
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic dual_issue();
        dispatch_entry_t e0;
        dispatch_entry_t e1;
        int acc;
        e0 = make_entry(32'h100, 1'b0, 6'd3, 1'b1, 6'd0, 1'b1, 6'd33, 5'd1);
        e1 = make_entry(32'h104, 1'b1, 6'd10, 1'b1, 6'd63, 1'b1, 6'd34, 5'd2);
        // no register write on this one
        e1.rf_we = 1'b0;
        send(e0, e1, acc);
        expect_exec(0, e0, acc + 1);
        expect_exec(1, e1, acc + 1);
        wait_drain(10);
    endtask

    task automatic wakeup_and_bypass();
        dispatch_entry_t a;
        dispatch_entry_t b;
        int acc;
        a = make_entry(32'h200, 1'b0, 6'd5, 1'b0, 6'd6, 1'b1, 6'd35, 5'd3);
        b = make_entry(32'h204, 1'b1, 6'd7, 1'b1, 6'd8, 1'b1, 6'd36, 5'd4);
        send(a, '0, acc);
        // waiting on r5, the monitor flags anything issued meanwhile
        repeat (4) @(negedge clk);
        @(posedge clk);
        drive_wb(0, 6'd5, next_rand());
        @(negedge clk);
        expect_exec(0, a, cycle + 2);
        @(posedge clk);
        wb <= '0;
        wait_drain(10);
        // writebacks during the issue cycle go through the bypass
        send(b, '0, acc);
        expect_exec(1, b, acc + 1);
        @(posedge clk);
        drive_wb(0, 6'd8, next_rand());
        drive_wb(1, 6'd7, next_rand());
        @(posedge clk);
        wb <= '0;
        wait_drain(10);
    endtask

    task automatic backpressure_order();
        dispatch_entry_t e [QUEUE_DEPTH];
        int acc;
        int rel;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            e[i] = make_entry(word_t'(32'h1000 + 4 * i), 1'b0, preg_t'(i + 1), 1'b1,
                preg_t'(i + 20), 1'b1, preg_t'(i + 40), rob_tag_t'(i));
        end
        @(posedge clk);
        pipe_ready <= 2'b10;
        for (int i = 0; i < QUEUE_DEPTH; i += 2) begin
            send(e[i], e[i + 1], acc);
        end
        @(negedge clk);
        assert (!in_ready) else fail_now("in_ready stayed high with a full queue");
        @(posedge clk);
        pipe_ready <= 2'b11;
        @(negedge clk);
        rel = cycle;
        // oldest first, one per cycle once the pipe opens
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            expect_exec(0, e[i], rel + 1 + i);
        end
        wait_drain(QUEUE_DEPTH + 4);
        assert (in_ready) else fail_now("in_ready low after the queue drained");
    endtask

    task automatic flush_queue();
        int acc;
        @(posedge clk);
        pipe_ready <= 2'b00;
        // fill the queue so in_ready is low before the flush
        for (int i = 0; i < QUEUE_DEPTH; i += 2) begin
            send(make_entry(word_t'(32'h300 + 8 * i), 1'b0, 6'd1, 1'b1, 6'd2, 1'b1,
                    preg_t'(i + 41), rob_tag_t'(i + 10)),
                make_entry(word_t'(32'h304 + 8 * i), 1'b1, 6'd3, 1'b1, 6'd4, 1'b1,
                    preg_t'(i + 42), rob_tag_t'(i + 11)), acc);
        end
        @(negedge clk);
        assert (!in_ready) else fail_now("in_ready stayed high with a full queue");
        // pipes reopen at the flush edge, so select is busy while it clears
        @(posedge clk);
        flush <= 1'b1;
        pipe_ready <= 2'b11;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        assert (in_ready) else fail_now("in_ready low right after flush");
        repeat (8) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        dispatch = '0;
        wb = '0;
        pipe_ready = 2'b11;
        cycle = 0;
        error_count = 0;
        lcg_state = 32'heb6a;
        for (int r = 0; r < NUM_PREGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        reset_state_check();
        load_regs();
        dual_issue();
        wakeup_and_bypass();
        backpressure_order();
        flush_queue();
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/issue_pkg.sv
hw/issue_regfile.sv
hw/operand_bypass.sv
hw/issue_queue.sv
hw/issue_select.sv
hw/issue_stage.sv
tests/issue_stage_checker.sv
tests/issue_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module issue_stage_tb -f build.f \
    -o issue_stage_sim

./obj_dir/issue_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
